/* test/game_over_input.txt */
# Columns, all hex: test video_on pixel_x pixel_y expected_rgb
# Text after the fifth column is a note
1 0 11A 0AC 00  skull cell, video off
1 0 063 11C 00  G top bar, video off
1 1 11A 0AC 1F  skull cell, video on
1 1 063 11C 18  G top bar, video on
2 1 12E 0B6 00  left eye
2 1 11F 0B6 1F  row 6 column 1
2 1 13D 0C5 00  nose
2 1 133 0C5 1F  row 9 column 5
2 1 11F 0D4 00  tooth gap
2 1 124 0D4 1F  tooth
2 1 124 098 00  outline corner
2 1 14C 0E3 1F  jaw outline
3 1 051 13B 18  G left bar
3 1 063 12C 00  G counter
3 1 075 14A 18  G lower right bar
3 1 09A 13B 18  A middle bar
3 1 09A 12C 00  A counter
3 1 0BF 14A 18  M left bar
3 1 108 159 18  E bottom bar
3 1 1EC 13B 18  second E middle bar
3 1 1EC 14A 00  second E lower gap
3 1 176 13B 00  O interior
3 1 164 13B 18  O left bar
3 1 22D 12C 18  R upper right bar
3 1 21B 12C 00  R bowl
4 1 07E 13B 00  gap after G
4 1 13F 11C 00  space cell
4 1 04C 11C 00  left of the text
4 1 232 11C 00  right of the text
4 1 12C 0E6 00  row 230 below the skull
4 1 064 117 00  row 279 above the text
5 1 11A 0AC 1F  skull
5 1 209 154 18  R left bar
5 0 11A 0AC 00  blanked skull
5 1 13D 0C5 00  nose
5 1 010 010 00  background
5 1 165 0CA 1F  skull right edge
5 1 231 11C 18  last text column

/* compile.f */
+incdir+src
src/screen_geometry_pkg.sv
src/glyph_color_pkg.sv
src/pixel_region_decode.sv
src/skull_bitmap.sv
src/letter_glyph.sv
src/pixel_color_stage.sv
src/game_over_screen.sv
test/game_over_screen_asserts.sv
test/game_over_screen_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module game_over_screen_tb \
    -f compile.f \
    -o game_over_sim

output=$(./obj_dir/game_over_sim)
echo "$output"
echo "$output" | grep -qx '>>> PASS'

/* test/game_over_screen_tb.sv */
`timescale 1ns/100ps

module game_over_screen_tb
    import screen_geometry_pkg::*;
    import glyph_color_pkg::*;
;

    localparam int  MAX_LINES    = 128;
    localparam int  RESET_CYCLES = 10;
    localparam int  WAIT_LIMIT   = 4;       // Falling edges allowed per rising edge
    localparam byte COMMENT_CHAR = 8'h23;   // '#'

    logic   clk = 1'b0;
    logic   arst_n;
    logic   video_on;
    coord_t pixel_x;
    coord_t pixel_y;
    rgb_t   vga_rgb;

    // Stimulus table, one entry per data line
    int     line_test  [MAX_LINES];
    logic   line_video [MAX_LINES];
    coord_t line_x     [MAX_LINES];
    coord_t line_y     [MAX_LINES];
    rgb_t   line_rgb   [MAX_LINES];
    int     line_count;

    int rise_count = 0;
    int cur_test;
    int cur_checks;
    int cur_errors;
    int tests_passed;
    int tests_failed;
    int total_checks;

    game_over_screen dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .video_on (video_on),
        .pixel_x  (pixel_x),
        .pixel_y  (pixel_y),
        .vga_rgb  (vga_rgb)
    );

    always #10 clk = ~clk;

    always @(posedge clk) rise_count <= rise_count + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("run aborted: %s", why);
        $display(">>> FAIL");
        $finish;
    endtask

    // Step to the falling edge after the next rising edge
    task automatic next_falling_edge();
        int start;
        int guard;
        start = rise_count;
        guard = 0;
        while (rise_count == start && guard < WAIT_LIMIT) begin
            @(negedge clk);
            guard++;
        end
        if (rise_count == start) begin
            abort_run("timeout while waiting for a rising clock edge");
        end
    endtask

    task automatic check_value(input string name, input rgb_t actual, input rgb_t expected);
        cur_checks++;
        total_checks++;
        if (actual !== expected) begin
            cur_errors++;
            $display("error: %s = 0x%02h, expected 0x%02h (test %0d)",
                     name, actual, expected, cur_test);
        end
    endtask

    task automatic close_test();
        $display("test %0d done: %0d checks, %0d mismatches", cur_test, cur_checks, cur_errors);
        if (cur_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        cur_checks = 0;
        cur_errors = 0;
    endtask

    task automatic enter_test(input int num);
        if (num != cur_test) begin
            close_test();
            cur_test = num;
        end
    endtask

    task automatic load_stimulus(output bit ok, output string why);
        int    fd;
        int    code;
        int    t;
        int    v;
        int    x;
        int    y;
        int    e;
        string text;
        ok         = 1'b1;
        why        = "";
        line_count = 0;
        fd = $fopen("test/game_over_input.txt", "r");
        if (fd == 0) begin
            ok  = 1'b0;
            why = "cannot open test/game_over_input.txt";
        end else begin
            while (ok && !$feof(fd) && line_count < MAX_LINES) begin
                text = "";
                code = $fgets(text, fd);
                if (text.len() > 0 && text.getc(0) != COMMENT_CHAR) begin
                    code = $sscanf(text, "%h %h %h %h %h", t, v, x, y, e);
                    if (code == 5) begin
                        line_test[line_count]  = t;
                        line_video[line_count] = (v != 0);
                        line_x[line_count]     = coord_t'(x);
                        line_y[line_count]     = coord_t'(y);
                        line_rgb[line_count]   = rgb_t'(e);
                        line_count++;
                    end else if (code > 0) begin
                        ok  = 1'b0;
                        why = $sformatf("malformed stimulus line: %s", text);
                    end
                end
            end
            $fclose(fd);
            if (ok && line_count == 0) begin
                ok  = 1'b0;
                why = "stimulus file holds no pixels";
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        bit    loaded;
        string why;
        arst_n       = 1'b0;
        video_on     = 1'b1;
        pixel_x      = coord_t'(282);    // Lit skull cell, hidden while in reset
        pixel_y      = coord_t'(172);
        cur_test     = 1;
        cur_checks   = 0;
        cur_errors   = 0;
        tests_passed = 0;
        tests_failed = 0;
        total_checks = 0;
        load_stimulus(loaded, why);
        if (!loaded) begin
            abort_run(why);
        end else begin
            next_falling_edge();
            for (int c = 0; c < RESET_CYCLES; c++) begin
                check_value("vga_rgb", vga_rgb, rgb_t'(COLOR_BLACK));
                next_falling_edge();
            end
            arst_n = 1'b1;
            // Pixel i goes in now, its colour shows two falling edges later
            for (int i = 0; i < line_count + 2; i++) begin
                if (i >= 2) begin
                    enter_test(line_test[i - 2]);
                    check_value("vga_rgb", vga_rgb, line_rgb[i - 2]);
                end else begin
                    check_value("vga_rgb", vga_rgb, rgb_t'(COLOR_BLACK));
                end
                if (i < line_count) begin
                    video_on = line_video[i];
                    pixel_x  = line_x[i];
                    pixel_y  = line_y[i];
                end else begin
                    video_on = 1'b0;
                    pixel_x  = '0;
                    pixel_y  = '0;
                end
                next_falling_edge();
            end
            close_test();
            $display("tests passed: %0d, failed: %0d, checks: %0d, assertion failures: %0d",
                     tests_passed, tests_failed, total_checks, dut.u_asserts.failures);
            if (tests_failed == 0 && dut.u_asserts.failures == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

/* test/game_over_screen_asserts.sv */
`timescale 1ns/100ps

module game_over_screen_asserts
    import glyph_color_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic video_on,
    input rgb_t vga_rgb
);

    int failures = 0;       // Count of failed assertions

    // Only the three palette entries reach the DAC
    a_palette_only: assert property (@(posedge clk)
        (vga_rgb == rgb_t'(COLOR_BLACK)) ||
        (vga_rgb == rgb_t'(COLOR_RED))   ||
        (vga_rgb == rgb_t'(COLOR_WHITE)))
        else begin
            $error("vga_rgb holds a colour outside the palette");
            failures = failures + 1;
        end

    a_reset_black: assert property (@(posedge clk)
        !arst_n |-> (vga_rgb == rgb_t'(COLOR_BLACK)))
        else begin
            $error("vga_rgb is not black during reset");
            failures = failures + 1;
        end

    // Two-stage pipeline, blanking shows up two edges later
    a_blank_latency: assert property (@(posedge clk) disable iff (!arst_n)
        !$past(video_on, 2) |-> (vga_rgb == rgb_t'(COLOR_BLACK)))
        else begin
            $error("vga_rgb is not black two cycles after video_on was low");
            failures = failures + 1;
        end

endmodule

bind game_over_screen game_over_screen_asserts u_asserts (
    .clk      (clk),
    .arst_n   (arst_n),
    .video_on (video_on),
    .vga_rgb  (vga_rgb)
);

/* src/game_over_screen.sv */
`timescale 1ns/100ps

module game_over_screen
    import screen_geometry_pkg::*;
    import glyph_color_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   video_on,
    input  coord_t pixel_x,
    input  coord_t pixel_y,
    output rgb_t   vga_rgb
);

    // Stage 1 outputs
    region_t region;
    glyph_t  glyph;
    coord_t  local_x;
    coord_t  local_y;

    // Shape lookups, combinational between the two registers
    logic    skull_on;
    logic    letter_on;

    pixel_region_decode u_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .video_on (video_on),
        .pixel_x  (pixel_x),
        .pixel_y  (pixel_y),
        .region   (region),
        .glyph    (glyph),
        .local_x  (local_x),
        .local_y  (local_y)
    );

    skull_bitmap u_skull (
        .local_x  (local_x),
        .local_y  (local_y),
        .skull_on (skull_on)
    );

    letter_glyph u_letter (
        .glyph     (glyph),
        .local_x   (local_x),
        .local_y   (local_y),
        .letter_on (letter_on)
    );

    pixel_color_stage u_color (
        .clk       (clk),
        .arst_n    (arst_n),
        .region    (region),
        .skull_on  (skull_on),
        .letter_on (letter_on),
        .vga_rgb   (vga_rgb)
    );

endmodule

/* src/pixel_color_stage.sv */
`timescale 1ns/100ps

module pixel_color_stage
    import screen_geometry_pkg::*;
    import glyph_color_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  region_t region,
    input  logic    skull_on,
    input  logic    letter_on,
    output rgb_t    vga_rgb
);

    palette_t color_d;

    // Palette lookup
    always_comb begin
        color_d = COLOR_BLACK;
        case (region)
            REGION_SKULL: if (skull_on) color_d = COLOR_WHITE;
            REGION_TEXT:  if (letter_on) color_d = COLOR_RED;
            default:      color_d = COLOR_BLACK;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_rgb <= rgb_t'(COLOR_BLACK);
        end else begin
            vga_rgb <= rgb_t'(color_d);
        end
    end

endmodule

/* src/letter_glyph.sv */
`timescale 1ns/100ps
`include "game_over_settings.svh"

module letter_glyph
    import screen_geometry_pkg::*;
    import glyph_color_pkg::*;
(
    input  glyph_t glyph,
    input  coord_t local_x,
    input  coord_t local_y,
    output logic   letter_on
);

    localparam int W    = `LETTER_W;
    localparam int H    = `LETTER_H;
    localparam int S    = `STROKE;
    localparam int HALF = H / 2;    // Row 35

    int   x;
    int   y;
    int   m_diag;                   // Diagonal offsets from the top or middle
    int   v_diag;
    int   r_diag;
    logic top_bar;
    logic bottom_bar;
    logic left_bar;
    logic right_bar;
    logic mid_bar;
    logic lower_half;

    assign x = int'(local_x);
    assign y = int'(local_y);

    ////////////////////////////////////////////////////////////////////////////
    // Shared strokes
    ////////////////////////////////////////////////////////////////////////////

    assign top_bar    = y < S;
    assign bottom_bar = y >= H - S;
    assign left_bar   = x < S;
    assign right_bar  = x >= W - S;
    assign mid_bar    = (y >= HALF - `MID_BAND / 2) && (y < HALF + `MID_BAND / 2);
    assign lower_half = y >= HALF;

    // M runs from the corners to the middle, V over the full height
    assign m_diag = (y * (W / 2 - S)) / HALF;
    assign v_diag = (y * (W / 2 - S / 2)) / H;
    assign r_diag = ((y - HALF) * (W - 2 * S)) / HALF;     // Leg of R, lower half only

    always_comb begin
        letter_on = 1'b0;
        case (glyph)
            GLYPH_G: begin
                letter_on = top_bar || left_bar || bottom_bar ||
                            (right_bar && lower_half) ||
                            (lower_half && (y < HALF + S) && (x >= W / 2));    // Inner spur
            end
            GLYPH_A: begin
                letter_on = top_bar || mid_bar || left_bar || right_bar;
            end
            GLYPH_M: begin
                if (left_bar || right_bar) begin
                    letter_on = 1'b1;
                end else if (!lower_half) begin
                    letter_on = ((x >= m_diag + S) && (x < m_diag + 2 * S)) ||
                                ((x >= W - 2 * S - m_diag) && (x < W - S - m_diag));
                end
            end
            GLYPH_E: begin
                letter_on = top_bar || mid_bar || bottom_bar || left_bar;
            end
            GLYPH_O: begin
                // Square ring with the corners cut
                letter_on = ((top_bar || bottom_bar) && !left_bar && !right_bar) ||
                            ((left_bar || right_bar) && !top_bar && !bottom_bar);
            end
            GLYPH_V: begin
                letter_on = ((x >= v_diag) && (x < v_diag + S)) ||
                            ((x >= W - S - v_diag) && (x < W - v_diag));
            end
            GLYPH_R: begin
                if (left_bar || top_bar || mid_bar || (right_bar && !lower_half)) begin
                    letter_on = 1'b1;
                end else if (lower_half) begin
                    letter_on = (x >= S + r_diag) && (x < 2 * S + r_diag);
                end
            end
            default: letter_on = 1'b0;     // GLYPH_NONE
        endcase
    end

endmodule

/* src/skull_bitmap.sv */
`timescale 1ns/100ps
`include "game_over_settings.svh"

module skull_bitmap
    import screen_geometry_pkg::*;
(
    input  coord_t local_x,
    input  coord_t local_y,
    output logic   skull_on
);

    logic [3:0]  col;
    logic [3:0]  row;
    logic [15:0] row_mask;      // Bit n lights grid column n

    // Grid cell of the offset, 0..15 inside the skull
    assign col = 4'(local_x / coord_t'(`SKULL_CELL));
    assign row = 4'(local_y / coord_t'(`SKULL_CELL));

    ////////////////////////////////////////////////////////////////////////////
    // 16x16 skull, column 15 on the left of each literal
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (row)
            // Rounded top of the cranium
            4'd0:    row_mask = 16'b0000_1111_1111_0000;
            4'd1:    row_mask = 16'b0011_0000_0000_1100;
            4'd2:    row_mask = 16'b0100_0000_0000_0010;
            4'd3:    row_mask = 16'b1000_0000_0000_0001;

            4'd4:    row_mask = 16'b1111_1111_1111_1111;
            // Eye holes at columns 3-6 and 9-12
            4'd5,
            4'd6,
            4'd7:    row_mask = 16'b1110_0001_1000_0111;
            4'd8:    row_mask = 16'b1111_1111_1111_1111;

            4'd9:    row_mask = 16'b1111_1110_0111_1111;     // Nose
            4'd10,
            4'd11:   row_mask = 16'b1111_1111_1111_1111;

            4'd12:   row_mask = 16'b1010_1010_0101_0101;     // Teeth

            // Jaw outline
            4'd13:   row_mask = 16'b0100_0000_0000_0010;
            4'd14:   row_mask = 16'b0011_0000_0000_1100;
            default: row_mask = 16'b0000_1111_1111_0000;
        endcase
    end

    assign skull_on = row_mask[col];

endmodule

/* src/pixel_region_decode.sv */
`timescale 1ns/100ps
`include "game_over_settings.svh"

module pixel_region_decode
    import screen_geometry_pkg::*;
    import glyph_color_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    video_on,
    input  coord_t  pixel_x,
    input  coord_t  pixel_y,
    output region_t region,
    output glyph_t  glyph,
    output coord_t  local_x,
    output coord_t  local_y
);

    localparam int TEXT_CELLS = 9;
    localparam int CELL_PITCH = `LETTER_W + `LETTER_GAP;

    // Region bounds, upper bounds exclusive
    localparam coord_t SKULL_X_LO = coord_t'(`SKULL_X0);
    localparam coord_t SKULL_X_HI = coord_t'(`SKULL_X0 + `SKULL_SIZE);
    localparam coord_t SKULL_Y_LO = coord_t'(`SKULL_Y0);
    localparam coord_t SKULL_Y_HI = coord_t'(`SKULL_Y0 + `SKULL_SIZE);
    localparam coord_t TEXT_X_LO  = coord_t'(`TEXT_X0);
    localparam coord_t TEXT_X_HI  = coord_t'(`TEXT_X0 + TEXT_CELLS * CELL_PITCH - `LETTER_GAP);
    localparam coord_t TEXT_Y_LO  = coord_t'(`TEXT_Y0);
    localparam coord_t TEXT_Y_HI  = coord_t'(`TEXT_Y0 + `LETTER_H);
    localparam coord_t LETTER_SPAN = coord_t'(`LETTER_W);

    // "GAME OVER", cell 4 is the space
    localparam glyph_t CELL_GLYPH [TEXT_CELLS] = '{
        GLYPH_G, GLYPH_A, GLYPH_M, GLYPH_E, GLYPH_NONE,
        GLYPH_O, GLYPH_V, GLYPH_E, GLYPH_R
    };

    logic    in_skull;
    logic    in_text;
    region_t region_d;
    glyph_t  glyph_d;
    coord_t  local_x_d;
    coord_t  local_y_d;

    // Left edge of a letter cell
    function automatic coord_t cell_origin(input int idx);
        return coord_t'(`TEXT_X0 + idx * CELL_PITCH);
    endfunction

    assign in_skull = (pixel_x >= SKULL_X_LO) && (pixel_x < SKULL_X_HI) &&
                      (pixel_y >= SKULL_Y_LO) && (pixel_y < SKULL_Y_HI);
    assign in_text  = (pixel_x >= TEXT_X_LO) && (pixel_x < TEXT_X_HI) &&
                      (pixel_y >= TEXT_Y_LO) && (pixel_y < TEXT_Y_HI);

    ////////////////////////////////////////////////////////////////////////////
    // Classification, skull wins over the text band
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        region_d  = REGION_BLANK;
        glyph_d   = GLYPH_NONE;
        local_x_d = '0;
        local_y_d = '0;
        if (video_on) begin
            if (in_skull) begin
                region_d  = REGION_SKULL;
                local_x_d = pixel_x - SKULL_X_LO;
                local_y_d = pixel_y - SKULL_Y_LO;
            end else if (in_text) begin
                region_d  = REGION_TEXT;
                local_y_d = pixel_y - TEXT_Y_LO;
                // Gaps match no cell and stay GLYPH_NONE
                for (int i = 0; i < TEXT_CELLS; i++) begin
                    if ((pixel_x >= cell_origin(i)) &&
                        (pixel_x < cell_origin(i) + LETTER_SPAN)) begin
                        glyph_d   = CELL_GLYPH[i];
                        local_x_d = pixel_x - cell_origin(i);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            region  <= REGION_BLANK;
            glyph   <= GLYPH_NONE;
            local_x <= '0;
            local_y <= '0;
        end else begin
            region  <= region_d;
            glyph   <= glyph_d;
            local_x <= local_x_d;
            local_y <= local_y_d;
        end
    end

endmodule

/* src/glyph_color_pkg.sv */
// Colours and letter shapes
package glyph_color_pkg;

    // 5-bit VGA colour as driven to the DAC
    typedef logic [4:0] rgb_t;

    // The three colours on the screen
    typedef enum logic [4:0] {
        COLOR_BLACK = 5'h00,
        COLOR_RED   = 5'h18,    // Kept below full scale
        COLOR_WHITE = 5'h1F
    } palette_t;

    // Letter shapes, the two E's share one
    typedef enum logic [2:0] {
        GLYPH_G    = 3'd0,
        GLYPH_A    = 3'd1,
        GLYPH_M    = 3'd2,
        GLYPH_E    = 3'd3,
        GLYPH_O    = 3'd4,
        GLYPH_V    = 3'd5,
        GLYPH_R    = 3'd6,
        GLYPH_NONE = 3'd7       // Space cell and inter-letter gaps
    } glyph_t;

endpackage

/* src/screen_geometry_pkg.sv */
`include "game_over_settings.svh"

// Pixel positions and the screen regions they fall into
package screen_geometry_pkg;

    // Absolute coordinate or offset inside a skull or letter cell
    typedef logic [`COORD_W-1:0] coord_t;

    // What the input side found at a pixel
    typedef enum logic [1:0] {
        REGION_BLANK = 2'd0,    // Background, or video_on low
        REGION_SKULL = 2'd1,    // Inside the 80x80 skull square
        REGION_TEXT  = 2'd2     // Inside the text band
    } region_t;

endpackage

/* src/game_over_settings.svh */
`ifndef GAME_OVER_SETTINGS_SVH
`define GAME_OVER_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Screen and coordinate width
////////////////////////////////////////////////////////////////////////////

`define COORD_W     11              // Covers 0..2047, enough for 640x480
`define SCREEN_W    640

////////////////////////////////////////////////////////////////////////////
// "GAME OVER" text geometry
////////////////////////////////////////////////////////////////////////////

`define LETTER_W    45
`define LETTER_H    70
`define LETTER_GAP  10

// First text row
`define TEXT_Y0     280

// Nine cells of 45 px with eight 10 px gaps, centred on the line (77)
`define TEXT_X0     ((`SCREEN_W - 9 * `LETTER_W - 8 * `LETTER_GAP) / 2)

// Stroke width of a bar, height of a middle bar
`define STROKE      9
`define MID_BAND    10

////////////////////////////////////////////////////////////////////////////
// Skull geometry
////////////////////////////////////////////////////////////////////////////

`define SKULL_SIZE  80
`define SKULL_X0    ((`SCREEN_W - `SKULL_SIZE) / 2)     // Centred, 280
`define SKULL_Y0    150
`define SKULL_CELL  5               // 80 px over a 16x16 grid

`endif
